//--- Bender.yml
package:
  name: dispatch_front

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - dispatch_if.sv
  - inst_queue.sv
  - decoder.sv
  - rename_regfile.sv
  - rob_alloc.sv
  - dispatch_top.sv
  - target: simulation
    files:
      - dispatch_chk.sv
      - dispatch_mon.sv
      - dispatch_tb.sv

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath, immediate and pc width.
`define XLEN 32

// architectural register name width.
`define NAMEW 5

// reorder buffer tags.
`define TAGW 3
`define ROBDEPTH 8

// default instruction queue depth.
`define IQDEPTH 4

`endif

//--- cpu_pkg.sv
package cpu_pkg;

    // decoded operation sent to the reservation stations.
    typedef enum logic [5:0] {
        Nop   = 6'd0,
        Lui,
        Auipc,
        Jal,
        Jalr,
        Beq,
        Bne,
        Blt,
        Bge,
        Bltu,
        Bgeu,
        Lb,
        Lh,
        Lw,
        Lbu,
        Lhu,
        Sb,
        Sh,
        Sw,
        Addi,
        Slti,
        Sltiu,
        Xori,
        Ori,
        Andi,
        Slli,
        Srli,
        Srai,
        Add,
        Sub,
        Sll,
        Slt,
        Sltu,
        Xor,
        Srl,
        Sra,
        Or,
        And
    } opT;

    // rv32i base integer major opcodes.
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opReg    = 7'b0110011
    } opcodeT;

endpackage

//--- decoder.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decoder
    import cpu_pkg::*;
(
    input  logic             headValid,
    input  logic [`XLEN-1:0] headInst,
    input  logic [`XLEN-1:0] headPc,
    input  logic             headPd,
    input  logic             rdy,
    input  logic             robFull,
    dispatch_if.decoder      dispatch
);
    opcodeT           opcode;
    logic [2:0]       funct3;
    logic [3:0]       funct;   // bit 30 and funct3.
    logic [`XLEN-1:0] imm;
    opT               op;

    assign opcode = opcodeT'(headInst[6:0]);
    assign funct3 = headInst[14:12];
    assign funct  = {headInst[30], headInst[14:12]};

    assign dispatch.en  = headValid && rdy && !robFull;
    assign dispatch.rs1 = headInst[19:15];
    assign dispatch.rs2 = headInst[24:20];
    assign dispatch.rd  = headInst[11:7];
    assign dispatch.pc  = headPc;
    assign dispatch.pd  = headPd;
    assign dispatch.imm = imm;
    assign dispatch.op  = op;

    // immediate by format, sign extended from bit 31.
    always_comb begin
        case (opcode)
            opLui, opAuipc: imm = {headInst[31:12], 12'b0};
            opJal: imm = {{(`XLEN-20){headInst[31]}}, headInst[19:12], headInst[20],
                          headInst[30:21], 1'b0};
            opBranch: imm = {{(`XLEN-12){headInst[31]}}, headInst[7], headInst[30:25],
                             headInst[11:8], 1'b0};
            opJalr, opLoad, opImm: imm = {{(`XLEN-11){headInst[31]}}, headInst[30:20]};
            opStore: imm = {{(`XLEN-11){headInst[31]}}, headInst[30:25], headInst[11:7]};
            default: imm = '0;
        endcase
    end

    always_comb begin
        op = Nop;   // anything unlisted.
        case (opcode)
            opLui:   op = Lui;
            opAuipc: op = Auipc;
            opJal:   op = Jal;
            opJalr:  op = Jalr;
            opBranch: begin
                case (funct3)
                    3'b000:  op = Beq;
                    3'b001:  op = Bne;
                    3'b100:  op = Blt;
                    3'b101:  op = Bge;
                    3'b110:  op = Bltu;
                    3'b111:  op = Bgeu;
                    default: op = Nop;
                endcase
            end
            opLoad: begin
                case (funct3)
                    3'b000:  op = Lb;
                    3'b001:  op = Lh;
                    3'b010:  op = Lw;
                    3'b100:  op = Lbu;
                    3'b101:  op = Lhu;
                    default: op = Nop;
                endcase
            end
            opStore: begin
                case (funct3)
                    3'b000:  op = Sb;
                    3'b001:  op = Sh;
                    3'b010:  op = Sw;
                    default: op = Nop;
                endcase
            end
            opImm: begin
                // bit 30 is immediate data except for the shifts.
                case (funct)
                    4'b0000, 4'b1000: op = Addi;
                    4'b0010, 4'b1010: op = Slti;
                    4'b0011, 4'b1011: op = Sltiu;
                    4'b0100, 4'b1100: op = Xori;
                    4'b0110, 4'b1110: op = Ori;
                    4'b0111, 4'b1111: op = Andi;
                    4'b0001:          op = Slli;
                    4'b0101:          op = Srli;
                    4'b1101:          op = Srai;
                    default:          op = Nop;
                endcase
            end
            opReg: begin
                case (funct)
                    4'b0000: op = Add;
                    4'b1000: op = Sub;
                    4'b0001: op = Sll;
                    4'b0010: op = Slt;
                    4'b0011: op = Sltu;
                    4'b0100: op = Xor;
                    4'b0101: op = Srl;
                    4'b1101: op = Sra;
                    4'b0110: op = Or;
                    4'b0111: op = And;
                    default: op = Nop;
                endcase
            end
            default: op = Nop;
        endcase
    end

endmodule

//--- dispatch_chk.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dispatch_chk (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic fetchValid,
    input logic queueFull,
    input logic robFull,
    input logic issueValid,
    input logic commitValid,
    input logic dispatchEn
);
    int failCount = 0;
    int outCount;   // tags allocated and not yet committed.

    always_ff @(posedge clk) begin
        if (rst) begin
            outCount <= 0;
        end else begin
            outCount <= outCount + int'(dispatchEn) - int'(commitValid);
        end
    end

    stallBlocksIssue: assert property (@(posedge clk) disable iff (rst) !rdy |=> !issueValid)
        else begin
            failCount++;
            $error("issue packet in the cycle after rdy was low");
        end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst) !(fetchValid && queueFull))
        else begin
            failCount++;
            $error("instruction pushed while the queue was full");
        end

    fullOnlyAtDepth: assert property (@(posedge clk) disable iff (rst)
        robFull |-> (outCount == `ROBDEPTH))
        else begin
            failCount++;
            $error("robFull high with %0d outstanding tags", outCount);
        end

endmodule

bind dispatch_top dispatch_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .rdy         (rdy),
    .fetchValid  (fetchValid),
    .queueFull   (queueFull),
    .robFull     (robFull),
    .issueValid  (issueValid),
    .commitValid (commitValid),
    .dispatchEn  (dispatchBus.en)
);

//--- dispatch_if.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

interface dispatch_if
    import cpu_pkg::*;
();
    logic              en;     // instruction taken this cycle.
    opT                op;
    logic [`NAMEW-1:0] rs1;
    logic [`NAMEW-1:0] rs2;
    logic [`NAMEW-1:0] rd;
    logic [`XLEN-1:0]  imm;
    logic [`XLEN-1:0]  pc;
    logic              pd;     // predicted taken.

    modport decoder (output en, op, rs1, rs2, rd, imm, pc, pd);

    modport regfile (input en, op, rs1, rs2, rd, imm, pc, pd);

endinterface

//--- dispatch_mon.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dispatch_mon
    import cpu_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              rdy,
    input logic              fetchValid,
    input logic [`XLEN-1:0]  fetchInst,
    input logic [`XLEN-1:0]  fetchPc,
    input logic              fetchPd,
    input logic              commitValid,
    input logic [`TAGW-1:0]  commitTag,
    input logic [`NAMEW-1:0] commitRd,
    input logic [`XLEN-1:0]  commitData,
    input logic              queueFull,
    input logic              robFull,
    input logic              issueValid,
    input opT                issueOp,
    input logic [`NAMEW-1:0] issueRd,
    input logic [`TAGW-1:0]  issueTag,
    input logic [`XLEN-1:0]  issueImm,
    input logic [`XLEN-1:0]  issuePc,
    input logic              issuePd,
    input logic              issueRs1Busy,
    input logic [`TAGW-1:0]  issueRs1Tag,
    input logic [`XLEN-1:0]  issueRs1Val,
    input logic              issueRs2Busy,
    input logic [`TAGW-1:0]  issueRs2Tag,
    input logic [`XLEN-1:0]  issueRs2Val
);
    // funct3 lookup per major opcode.
    localparam opT BranchOps [8] = '{Beq, Bne, Nop, Nop, Blt, Bge, Bltu, Bgeu};
    localparam opT LoadOps   [8] = '{Lb, Lh, Lw, Nop, Lbu, Lhu, Nop, Nop};
    localparam opT StoreOps  [8] = '{Sb, Sh, Sw, Nop, Nop, Nop, Nop, Nop};
    localparam opT ImmOps    [8] = '{Addi, Slli, Slti, Sltiu, Xori, Srli, Ori, Andi};
    localparam opT RegOps    [8] = '{Add, Sll, Slt, Sltu, Xor, Srl, Or, And};

    int               checkCount = 0;
    int               errorCount = 0;
    logic [`XLEN-1:0] mVal  [32];
    logic             mBusy [32];
    logic [`TAGW-1:0] mTag  [32];
    logic [64:0]      expQ  [$];   // {pd, pc, inst} in push order.
    int               nextTag;
    int               outstanding;
    logic             pRst = 1'b1;   // inputs as sampled by the coming edge.
    logic             pRdy;
    logic             pPush;
    logic [64:0]      pEntry;
    logic             pCommit;
    logic [`TAGW-1:0] pCommitTag;
    logic [4:0]       pCommitRd;
    logic [`XLEN-1:0] pCommitData;

    function automatic void refDecode(input logic [31:0] inst, output opT op,
                                      output logic [31:0] imm);
        logic [2:0] f3;
        logic       alt;
        f3  = inst[14:12];
        alt = inst[30];
        op  = Nop;
        imm = '0;
        case (inst[6:0])
            opLui, opAuipc: begin
                op  = inst[5] ? Lui : Auipc;
                imm = {inst[31:12], 12'h000};
            end
            opJal: begin
                op  = Jal;
                imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            end
            opJalr, opLoad, opImm: begin
                imm = 32'($signed(inst[31:20]));
                if (inst[6:0] == opJalr) begin
                    op = Jalr;
                end else if (inst[6:0] == opLoad) begin
                    op = LoadOps[f3];
                end else if (f3 == 3'd5) begin
                    op = alt ? Srai : Srli;
                end else if (!(f3 == 3'd1 && alt)) begin
                    op = ImmOps[f3];
                end
            end
            opBranch: begin
                op  = BranchOps[f3];
                imm = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            end
            opStore: begin
                op  = StoreOps[f3];
                imm = 32'($signed({inst[31:25], inst[11:7]}));
            end
            opReg: begin
                if (!alt) begin
                    op = RegOps[f3];
                end else if (f3 == 3'd0) begin
                    op = Sub;
                end else if (f3 == 3'd5) begin
                    op = Sra;
                end
            end
            default: op = Nop;
        endcase
    endfunction

    task automatic compareField(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic checkOperand(input string name, input logic [4:0] r, input logic busy,
                                input logic [`TAGW-1:0] tag, input logic [31:0] val);
        logic        eBusy;
        logic [31:0] eVal;
        if (r == 5'd0) begin
            eBusy = 1'b0;
            eVal  = '0;
        end else if (mBusy[r] && pCommit && (pCommitTag == mTag[r])) begin
            eBusy = 1'b0;   // same-cycle commit is forwarded.
            eVal  = pCommitData;
        end else begin
            eBusy = mBusy[r];
            eVal  = mVal[r];
        end
        compareField({name, "Busy"}, eBusy, busy);
        if (eBusy) begin
            compareField({name, "Tag"}, mTag[r], tag);
        end else begin
            compareField({name, "Val"}, eVal, val);
        end
    endtask

    // the packet seen here was registered at the edge just before.
    always @(negedge clk) begin
        logic        expIssue;
        logic [64:0] entry;
        logic [31:0] inst;
        opT          expOp;
        logic [31:0] expImm;
        if (pRst) begin
            for (int i = 0; i < 32; i++) begin
                mVal[i]  = '0;
                mBusy[i] = 1'b0;
                mTag[i]  = '0;
            end
            expQ.delete();
            nextTag     = 0;
            outstanding = 0;
        end else begin
            expIssue = (expQ.size() > 0) && pRdy && (outstanding < `ROBDEPTH);
            compareField("issueValid", expIssue, issueValid);
            inst = '0;
            if (expIssue) begin
                entry = expQ.pop_front();
                inst  = entry[31:0];
                refDecode(inst, expOp, expImm);
                compareField("issueOp", 32'(expOp), 32'(issueOp));
                compareField("issueImm", expImm, issueImm);
                compareField("issueRd", inst[11:7], issueRd);
                compareField("issueTag", nextTag, issueTag);
                compareField("issuePc", entry[63:32], issuePc);
                compareField("issuePd", entry[64], issuePd);
                checkOperand("issueRs1", inst[19:15], issueRs1Busy, issueRs1Tag, issueRs1Val);
                checkOperand("issueRs2", inst[24:20], issueRs2Busy, issueRs2Tag, issueRs2Val);
            end
            if (pCommit && (pCommitRd != 5'd0)) begin
                mVal[pCommitRd] = pCommitData;
                if (mTag[pCommitRd] == pCommitTag) begin
                    mBusy[pCommitRd] = 1'b0;
                end
            end
            if (expIssue && (inst[11:7] != 5'd0)) begin
                mBusy[inst[11:7]] = 1'b1;   // rename beats the commit.
                mTag[inst[11:7]]  = nextTag;
            end
            if (expIssue) begin
                nextTag = (nextTag + 1) % `ROBDEPTH;
            end
            outstanding = outstanding + int'(expIssue) - int'(pCommit);
            if (pPush) begin
                expQ.push_back(pEntry);
            end
            compareField("robFull", outstanding == `ROBDEPTH, robFull);
            compareField("queueFull", expQ.size() == `IQDEPTH, queueFull);
        end
        pRst        = rst;
        pRdy        = rdy;
        pPush       = fetchValid;
        pEntry      = {fetchPd, fetchPc, fetchInst};
        pCommit     = commitValid;
        pCommitTag  = commitTag;
        pCommitRd   = commitRd;
        pCommitData = commitData;
    end

endmodule

//--- dispatch_tb.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dispatch_tb
    import cpu_pkg::*;
();
    logic              clk;
    logic              rst;
    logic              rdy;
    logic              fetchValid;
    logic [`XLEN-1:0]  fetchInst;
    logic [`XLEN-1:0]  fetchPc;
    logic              fetchPd;
    logic              commitValid;
    logic [`TAGW-1:0]  commitTag;
    logic [`NAMEW-1:0] commitRd;
    logic [`XLEN-1:0]  commitData;
    logic              queueFull;
    logic              robFull;
    logic              issueValid;
    opT                issueOp;
    logic [`NAMEW-1:0] issueRd;
    logic [`TAGW-1:0]  issueTag;
    logic [`XLEN-1:0]  issueImm;
    logic [`XLEN-1:0]  issuePc;
    logic              issuePd;
    logic              issueRs1Busy;
    logic [`TAGW-1:0]  issueRs1Tag;
    logic [`XLEN-1:0]  issueRs1Val;
    logic              issueRs2Busy;
    logic [`TAGW-1:0]  issueRs2Tag;
    logic [`XLEN-1:0]  issueRs2Val;

    integer            seed;
    int                commitRate;    // commit chance in eighths.
    logic              rdyGaps;
    logic              holdCommits;   // commit only while the ROB is full.
    logic [7:0]        pending [$];   // {rd, tag} of issued instructions.
    int                pushedCount;
    int                issuedCount;
    logic [`XLEN-1:0]  pcNext;

    dispatch_top u_dispatch_top (.*);

    dispatch_mon u_mon (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (issueValid) begin
            pending.push_back({issueRd, issueTag});
            issuedCount++;
        end
    end

    // rdy pattern and in-order commits.
    always @(posedge clk) begin
        logic [7:0] oldest;
        #2;
        commitValid = 1'b0;
        rdy = rdyGaps ? (($random(seed) & 3) != 0) : 1'b1;
        if (!rst && (pending.size() > 0)) begin
            if (holdCommits ? robFull : (($random(seed) & 7) < commitRate)) begin
                oldest      = pending.pop_front();
                commitValid = 1'b1;
                commitTag   = oldest[2:0];
                commitRd    = oldest[7:3];
                commitData  = $random(seed);
            end
        end
    end

    function automatic int errorTotal();
        return u_mon.errorCount + u_dispatch_top.u_chk.failCount;
    endfunction

    // classes 0 to 8 are legal formats, 9 unknown opcodes, 10 unlisted functs.
    function automatic logic [31:0] makeInst(input int cls, input logic [4:0] mask);
        logic [31:0] r;
        logic [2:0]  f3;
        int          pick;
        r        = $random(seed);
        pick     = {$random(seed)} % 5;
        r[11:7]  = r[11:7] & mask;
        r[19:15] = r[19:15] & mask;
        r[24:20] = r[24:20] & mask;
        f3       = r[14:12];
        case (cls)
            0: r[6:0] = opLui;
            1: r[6:0] = opAuipc;
            2: r[6:0] = opJal;
            3: begin
                r[6:0] = opJalr;
                f3     = 3'd0;
            end
            4: begin
                r[6:0] = opBranch;
                f3[1]  = f3[1] & f3[2];   // skips 2 and 3.
            end
            5: begin
                r[6:0] = opLoad;
                f3     = (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3;
            end
            6: begin
                r[6:0] = opStore;
                f3     = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
            end
            7: begin
                r[6:0] = opImm;
                r[30]  = r[30] & (f3 != 3'd1);
            end
            8: begin
                r[6:0]  = opReg;
                r[31:25] = {1'b0, r[30] & (f3 == 3'd0 || f3 == 3'd5), 5'b0};
            end
            9: r[6:0] = (pick < 3) ? {r[6:2], 2'b00} : ((pick == 3) ? 7'h0f : 7'h73);
            default: begin
                r[6:0] = (pick == 0) ? opBranch : (pick == 1) ? opLoad :
                         (pick == 2) ? opStore : (pick == 3) ? opImm : opReg;
                f3     = (pick == 0) ? {2'b01, f3[0]} : (pick == 1) ? {2'b11, f3[0]} :
                         (pick == 2) ? {1'b1, f3[1:0]} : (pick == 3) ? 3'd1 : 3'd2;
                r[30]  = 1'b1;
            end
        endcase
        r[14:12] = f3;
        return r;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $finish;
    endtask

    task automatic pushInst(input logic [31:0] inst);
        int cycles;
        cycles = 0;
        while (queueFull) begin
            if (cycles == 200) begin
                abortRun("queueFull stayed high for 200 cycles");
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        fetchValid = 1'b1;
        fetchInst  = inst;
        fetchPc    = pcNext;
        fetchPd    = $random(seed);
        pcNext     = pcNext + 4;
        pushedCount++;
        @(posedge clk);
        #2;
        fetchValid = 1'b0;
    endtask

    task automatic waitDrain(input int limit);
        int cycles;
        cycles = 0;
        while (issuedCount < pushedCount) begin
            if (cycles == limit) begin
                abortRun($sformatf("only %0d of %0d instructions issued", issuedCount,
                                   pushedCount));
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic runTest(input string name, input int firstCls, input int numCls,
                           input logic [4:0] mask, input int rate, input logic gaps,
                           input logic hold, input int count);
        int c0;
        int e0;
        c0          = u_mon.checkCount;
        e0          = errorTotal();
        commitRate  = rate;
        rdyGaps     = gaps;
        holdCommits = hold;
        for (int i = 0; i < count; i++) begin
            pushInst(makeInst(firstCls + ({$random(seed)} % numCls), mask));
        end
        waitDrain(2000);
        repeat (2) @(posedge clk);
        #2;
        $display("%s: %0d checks, %0d errors", name, u_mon.checkCount - c0,
                 errorTotal() - e0);
    endtask

    initial begin
        seed        = 32'h7617_b637;
        clk         = 1'b0;
        rst         = 1'b1;
        rdy         = 1'b0;
        fetchValid  = 1'b0;
        fetchInst   = '0;
        fetchPc     = '0;
        fetchPd     = 1'b0;
        commitValid = 1'b0;
        commitTag   = '0;
        commitRd    = '0;
        commitData  = '0;
        commitRate  = 0;
        rdyGaps     = 1'b0;
        holdCommits = 1'b0;
        pushedCount = 0;
        issuedCount = 0;
        pcNext      = 32'h0000_1000;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        runTest("decode formats", 0, 9, 5'h1f, 5, 1'b0, 1'b0, 80);
        runTest("illegal encodings", 9, 2, 5'h1f, 5, 1'b0, 1'b0, 40);
        runTest("renaming", 7, 2, 5'h03, 1, 1'b0, 1'b0, 60);
        runTest("commit and forwarding", 7, 2, 5'h03, 7, 1'b0, 1'b0, 60);
        runTest("back-pressure and order", 0, 9, 5'h07, 0, 1'b1, 1'b1, 100);
        repeat (4) @(posedge clk);
        $display("5 tests, %0d checks, %0d errors", u_mon.checkCount, errorTotal());
        if (errorTotal() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- dispatch_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dispatch_top
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchValid,
    input  logic [`XLEN-1:0]  fetchInst,
    input  logic [`XLEN-1:0]  fetchPc,
    input  logic              fetchPd,
    input  logic              commitValid,
    input  logic [`TAGW-1:0]  commitTag,
    input  logic [`NAMEW-1:0] commitRd,
    input  logic [`XLEN-1:0]  commitData,
    output logic              queueFull,
    output logic              robFull,
    output logic              issueValid,
    output opT                issueOp,
    output logic [`NAMEW-1:0] issueRd,
    output logic [`TAGW-1:0]  issueTag,
    output logic [`XLEN-1:0]  issueImm,
    output logic [`XLEN-1:0]  issuePc,
    output logic              issuePd,
    output logic              issueRs1Busy,
    output logic [`TAGW-1:0]  issueRs1Tag,
    output logic [`XLEN-1:0]  issueRs1Val,
    output logic              issueRs2Busy,
    output logic [`TAGW-1:0]  issueRs2Tag,
    output logic [`XLEN-1:0]  issueRs2Val
);
    logic             headValid;
    logic [`XLEN-1:0] headInst;
    logic [`XLEN-1:0] headPc;
    logic             headPd;
    logic [`TAGW-1:0] allocTag;

    dispatch_if dispatchBus ();

    inst_queue u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (fetchValid),
        .pushInst  (fetchInst),
        .pushPc    (fetchPc),
        .pushPd    (fetchPd),
        .pop       (dispatchBus.en),   // dispatch consumes the head.
        .headValid (headValid),
        .headInst  (headInst),
        .headPc    (headPc),
        .headPd    (headPd),
        .full      (queueFull)
    );

    decoder u_decoder (
        .headValid (headValid),
        .headInst  (headInst),
        .headPc    (headPc),
        .headPd    (headPd),
        .rdy       (rdy),
        .robFull   (robFull),
        .dispatch  (dispatchBus.decoder)
    );

    rename_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .dispatch     (dispatchBus.regfile),
        .allocTag     (allocTag),
        .commitValid  (commitValid),
        .commitTag    (commitTag),
        .commitRd     (commitRd),
        .commitData   (commitData),
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .issueRd      (issueRd),
        .issueTag     (issueTag),
        .issueImm     (issueImm),
        .issuePc      (issuePc),
        .issuePd      (issuePd),
        .issueRs1Busy (issueRs1Busy),
        .issueRs1Tag  (issueRs1Tag),
        .issueRs1Val  (issueRs1Val),
        .issueRs2Busy (issueRs2Busy),
        .issueRs2Tag  (issueRs2Tag),
        .issueRs2Val  (issueRs2Val)
    );

    rob_alloc u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc       (dispatchBus.en),
        .commitValid (commitValid),
        .allocTag    (allocTag),
        .full        (robFull)
    );

endmodule

//--- inst_queue.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module inst_queue #(
    parameter int Depth = `IQDEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [`XLEN-1:0] pushInst,
    input  logic [`XLEN-1:0] pushPc,
    input  logic             pushPd,
    input  logic             pop,
    output logic             headValid,
    output logic [`XLEN-1:0] headInst,
    output logic [`XLEN-1:0] headPc,
    output logic             headPd,
    output logic             full
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    logic [`XLEN-1:0] instMem [Depth];
    logic [`XLEN-1:0] pcMem   [Depth];
    logic             pdMem   [Depth];
    logic [PtrW-1:0]  rdPtr;
    logic [PtrW-1:0]  wrPtr;
    logic [CntW-1:0]  count;
    logic             doPush;
    logic             doPop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPop  = pop && headValid;
    assign doPush = push && (!full || doPop);   // a same-cycle pop frees a slot.

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            instMem[wrPtr] <= pushInst;
            pcMem[wrPtr]   <= pushPc;
            pdMem[wrPtr]   <= pushPd;
        end
    end

    assign headValid = (count != '0);
    assign headInst  = instMem[rdPtr];   // oldest entry.
    assign headPc    = pcMem[rdPtr];
    assign headPd    = pdMem[rdPtr];
    assign full      = (count == CntW'(Depth));

endmodule

//--- rename_regfile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module rename_regfile
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    dispatch_if.regfile       dispatch,
    input  logic [`TAGW-1:0]  allocTag,
    input  logic              commitValid,
    input  logic [`TAGW-1:0]  commitTag,
    input  logic [`NAMEW-1:0] commitRd,
    input  logic [`XLEN-1:0]  commitData,
    output logic              issueValid,
    output opT                issueOp,
    output logic [`NAMEW-1:0] issueRd,
    output logic [`TAGW-1:0]  issueTag,
    output logic [`XLEN-1:0]  issueImm,
    output logic [`XLEN-1:0]  issuePc,
    output logic              issuePd,
    output logic              issueRs1Busy,
    output logic [`TAGW-1:0]  issueRs1Tag,
    output logic [`XLEN-1:0]  issueRs1Val,
    output logic              issueRs2Busy,
    output logic [`TAGW-1:0]  issueRs2Tag,
    output logic [`XLEN-1:0]  issueRs2Val
);
    localparam int NumRegs = 1 << `NAMEW;

    logic [`XLEN-1:0] regVal  [NumRegs];
    logic             regBusy [NumRegs];
    logic [`TAGW-1:0] regTag  [NumRegs];   // producer of the pending value.
    logic             rs1Busy;
    logic [`TAGW-1:0] rs1Tag;
    logic [`XLEN-1:0] rs1Val;
    logic             rs2Busy;
    logic [`TAGW-1:0] rs2Tag;
    logic [`XLEN-1:0] rs2Val;

    function automatic void readOperand(
        input  logic [`NAMEW-1:0] name,
        output logic              busy,
        output logic [`TAGW-1:0]  tag,
        output logic [`XLEN-1:0]  val
    );
        tag = regTag[name];
        if (name == '0) begin
            busy = 1'b0;
            val  = '0;
        end else if (regBusy[name] && commitValid && (commitTag == regTag[name])) begin
            busy = 1'b0;   // forwarded from the commit port.
            val  = commitData;
        end else begin
            busy = regBusy[name];
            val  = regVal[name];
        end
    endfunction

    always_comb begin
        readOperand(dispatch.rs1, rs1Busy, rs1Tag, rs1Val);
        readOperand(dispatch.rs2, rs2Busy, rs2Tag, rs2Val);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regVal[i]  <= '0;
                regBusy[i] <= 1'b0;
                regTag[i]  <= '0;
            end
            issueValid <= 1'b0;
        end else begin
            issueValid <= dispatch.en;
            if (commitValid && (commitRd != '0)) begin
                regVal[commitRd] <= commitData;
                if (regTag[commitRd] == commitTag) begin
                    regBusy[commitRd] <= 1'b0;   // stale tags leave it busy.
                end
            end
            if (dispatch.en && (dispatch.rd != '0)) begin
                regBusy[dispatch.rd] <= 1'b1;   // overrides a same-cycle commit.
                regTag[dispatch.rd]  <= allocTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch.en) begin
            issueOp      <= dispatch.op;
            issueRd      <= dispatch.rd;
            issueTag     <= allocTag;
            issueImm     <= dispatch.imm;
            issuePc      <= dispatch.pc;
            issuePd      <= dispatch.pd;
            issueRs1Busy <= rs1Busy;
            issueRs1Tag  <= rs1Tag;
            issueRs1Val  <= rs1Val;
            issueRs2Busy <= rs2Busy;
            issueRs2Tag  <= rs2Tag;
            issueRs2Val  <= rs2Val;
        end
    end

endmodule

//--- rob_alloc.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module rob_alloc (
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc,
    input  logic             commitValid,
    output logic [`TAGW-1:0] allocTag,
    output logic             full
);
    logic [`TAGW:0]   count;     // outstanding tags.
    logic [`TAGW-1:0] nextTag;

    // wraps modulo the entry count.
    assign nextTag = allocTag + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            allocTag <= '0;
        end else if (alloc) begin
            allocTag <= nextTag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({alloc, commitValid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither.
            endcase
        end
    end

    assign full = (count == (`TAGW+1)'(`ROBDEPTH));

endmodule

//--- sim.f
+incdir+.
cpu_pkg.sv
dispatch_if.sv
inst_queue.sv
decoder.sv
rename_regfile.sv
rob_alloc.sv
dispatch_top.sv
dispatch_chk.sv
dispatch_mon.sv
dispatch_tb.sv
